/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := tb_ex_stage
FILELIST := mips_ex.f
OBJ_DIR  := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* alu.sv */
`timescale 1ns/100ps
module alu #(
    parameter int NB_DATA = 32
) (
    input  mips_ex_pkg::alu_op_e             i_alu_op,
    input  logic [NB_DATA-1:0]               i_data_a,
    input  logic [NB_DATA-1:0]               i_data_b,
    input  logic [mips_ex_pkg::NB_SHAMT-1:0] i_shift_amt,
    output logic [NB_DATA-1:0]               o_result
);
    import mips_ex_pkg::*;

    logic a_lt_b;   // Signed compare for slt
    logic a_eq_b;

    assign a_lt_b = $signed(i_data_a) < $signed(i_data_b);
    assign a_eq_b = (i_data_a == i_data_b);

    always_comb begin
        case (i_alu_op)
            ALU_SLL: o_result = i_data_b << i_shift_amt;
            ALU_SRL: o_result = i_data_b >> i_shift_amt;
            ALU_SRA: o_result = $signed(i_data_b) >>> i_shift_amt;  // Sign fill
            ALU_ADD: o_result = i_data_a + i_data_b;
            ALU_SUB: o_result = i_data_a - i_data_b;
            ALU_AND: o_result = i_data_a & i_data_b;
            ALU_OR:  o_result = i_data_a | i_data_b;
            ALU_XOR: o_result = i_data_a ^ i_data_b;
            ALU_NOR: o_result = ~(i_data_a | i_data_b);
            ALU_SLT: o_result = {{(NB_DATA-1){1'b0}}, a_lt_b};
            ALU_LUI: o_result = i_data_b << NB_IMM;                 // Immediate to upper half
            ALU_BEQ: o_result = {{(NB_DATA-1){1'b0}}, a_eq_b};
            ALU_BNE: o_result = {{(NB_DATA-1){1'b0}}, ~a_eq_b};
            default: o_result = '0;
        endcase
    end

endmodule

/* alu_control.sv */
`timescale 1ns/100ps
module alu_control (
    input  mips_isa_pkg::funct_e  i_funct_code,         // Function code for R-type
    input  mips_isa_pkg::opcode_e i_alu_op,             // Primary opcode
    output mips_ex_pkg::alu_op_e  o_alu_ctrl,
    output logic                  o_shamt_ctrl,         // 0 shamt field, 1 data_a
    output logic                  o_imm_ctrl,           // B from immediate
    output logic                  o_imm_zext,           // Zero-extend immediate
    output logic                  o_last_register_ctrl, // Result is link address
    output logic                  o_reg_dst,            // Write rd instead of rt
    output logic                  o_reg_write,
    output logic                  o_branch,             // beq or bne
    output logic                  o_illegal
);
    import mips_isa_pkg::*;
    import mips_ex_pkg::*;

    always_comb begin
        // Unknown codes fall through with everything cleared
        o_alu_ctrl           = ALU_SLL;
        o_shamt_ctrl         = 1'b0;
        o_imm_ctrl           = 1'b0;
        o_imm_zext           = 1'b0;
        o_last_register_ctrl = 1'b0;
        o_reg_dst            = 1'b0;
        o_reg_write          = 1'b0;
        o_branch             = 1'b0;
        o_illegal            = 1'b0;

        case (i_alu_op)
            OP_RTYPE: begin
                o_reg_dst    = 1'b1;
                o_reg_write  = 1'b1;
                o_shamt_ctrl = 1'b1;                    // Variable shifts take rs
                case (i_funct_code)
                    FN_SLL: begin
                        o_alu_ctrl   = ALU_SLL;
                        o_shamt_ctrl = 1'b0;            // Shamt field
                    end
                    FN_SRL: begin
                        o_alu_ctrl   = ALU_SRL;
                        o_shamt_ctrl = 1'b0;
                    end
                    FN_SRA: begin
                        o_alu_ctrl   = ALU_SRA;
                        o_shamt_ctrl = 1'b0;
                    end
                    FN_SLLV:         o_alu_ctrl = ALU_SLL;
                    FN_SRLV:         o_alu_ctrl = ALU_SRL;
                    FN_SRAV:         o_alu_ctrl = ALU_SRA;
                    FN_ADD, FN_ADDU: o_alu_ctrl = ALU_ADD;  // No overflow trap
                    FN_SUB, FN_SUBU: o_alu_ctrl = ALU_SUB;
                    FN_AND:          o_alu_ctrl = ALU_AND;
                    FN_OR:           o_alu_ctrl = ALU_OR;
                    FN_XOR:          o_alu_ctrl = ALU_XOR;
                    FN_NOR:          o_alu_ctrl = ALU_NOR;
                    FN_SLT:          o_alu_ctrl = ALU_SLT;
                    FN_JALR: begin
                        o_shamt_ctrl         = 1'b0;
                        o_last_register_ctrl = 1'b1;    // PC+8 into rd
                    end
                    default: begin
                        o_reg_dst    = 1'b0;
                        o_reg_write  = 1'b0;
                        o_shamt_ctrl = 1'b0;
                        o_illegal    = 1'b1;
                    end
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LWU, OP_LBU, OP_LHU, OP_ADDI: begin
                o_alu_ctrl   = ALU_ADD;                 // Base plus offset
                o_shamt_ctrl = 1'b1;
                o_imm_ctrl   = 1'b1;
                o_reg_write  = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                o_alu_ctrl   = ALU_ADD;                 // Address only, no write
                o_shamt_ctrl = 1'b1;
                o_imm_ctrl   = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                o_alu_ctrl   = (i_alu_op == OP_ANDI) ? ALU_AND :
                               (i_alu_op == OP_ORI)  ? ALU_OR  : ALU_XOR;
                o_shamt_ctrl = 1'b1;
                o_imm_ctrl   = 1'b1;
                o_imm_zext   = 1'b1;                    // Logical immediates
                o_reg_write  = 1'b1;
            end
            OP_LUI, OP_SLTI: begin
                o_alu_ctrl   = (i_alu_op == OP_LUI) ? ALU_LUI : ALU_SLT;
                o_shamt_ctrl = 1'b1;
                o_imm_ctrl   = 1'b1;
                o_reg_write  = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                o_alu_ctrl   = (i_alu_op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
                o_shamt_ctrl = 1'b1;
                o_branch     = 1'b1;                    // Compare rs with rt
            end
            OP_JAL: begin
                o_shamt_ctrl         = 1'b1;
                o_last_register_ctrl = 1'b1;            // PC+8 into $ra
                o_reg_write          = 1'b1;
            end
            default: o_illegal = 1'b1;
        endcase
    end

    // Link select and illegal decode are exclusive
    always_comb begin
        assert (!(o_last_register_ctrl && o_illegal))
            else $error("alu_control: link select set on illegal instruction");
    end

endmodule

/* ex_checker.sv */
`timescale 1ns/100ps
module ex_checker #(
    parameter int NB_DATA = 32
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_valid,
    input  logic [mips_ex_pkg::NB_OPCODE-1:0]   i_opcode,
    input  logic [mips_ex_pkg::NB_FCODE-1:0]    i_funct,
    input  logic [mips_ex_pkg::NB_SHAMT-1:0]    i_shamt,
    input  logic [mips_ex_pkg::NB_IMM-1:0]      i_imm,
    input  logic [NB_DATA-1:0]                  i_rs_data,
    input  logic [NB_DATA-1:0]                  i_rt_data,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rt_addr,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rd_addr,
    input  logic [NB_DATA-1:0]                  i_pc,
    input  logic                                i_ex_valid,       // DUT outputs from here
    input  logic [NB_DATA-1:0]                  i_ex_result,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_ex_wr_addr,
    input  logic                                i_ex_reg_write,
    input  logic                                i_ex_branch_cond,
    input  logic                                i_ex_illegal,
    output int                                  o_error_count,
    output int                                  o_result_count    // Valid results from the DUT
);
    import mips_isa_pkg::*;

    localparam int RESET_TIMEOUT = 50;

    typedef struct packed {
        logic               valid;
        logic               reg_write;
        logic               branch_cond;
        logic               illegal;
        logic [NB_DATA-1:0] result;
        logic [4:0]         wr_addr;
    } expect_t;

    expect_t model_q[$];                // Never deeper than one, latency is fixed
    expect_t head;
    int      err_count    = 0;
    int      result_count = 0;
    logic    reset_timeout;

    assign o_error_count  = err_count + (reset_timeout ? 1 : 0);
    assign o_result_count = result_count;

    // Reference model of the stage, one instruction at the current inputs
    function automatic expect_t predict_outputs();
        expect_t            e;
        logic [NB_DATA-1:0] sext;
        logic [NB_DATA-1:0] zext;
        sext = {{(NB_DATA-16){i_imm[15]}}, i_imm};
        zext = {{(NB_DATA-16){1'b0}}, i_imm};
        e           = '0;
        e.valid     = i_valid;
        e.reg_write = i_valid;
        e.wr_addr   = i_rt_addr;        // I-type target
        case (i_opcode)
            OP_RTYPE: begin
                e.wr_addr = i_rd_addr;
                case (i_funct)
                    FN_SLL:          e.result = i_rt_data << i_shamt;
                    FN_SRL:          e.result = i_rt_data >> i_shamt;
                    FN_SRA:          e.result = $signed(i_rt_data) >>> i_shamt;
                    FN_SLLV:         e.result = i_rt_data << i_rs_data[4:0];
                    FN_SRLV:         e.result = i_rt_data >> i_rs_data[4:0];
                    FN_SRAV:         e.result = $signed(i_rt_data) >>> i_rs_data[4:0];
                    FN_ADD, FN_ADDU: e.result = i_rs_data + i_rt_data;
                    FN_SUB, FN_SUBU: e.result = i_rs_data - i_rt_data;
                    FN_AND:          e.result = i_rs_data & i_rt_data;
                    FN_OR:           e.result = i_rs_data | i_rt_data;
                    FN_XOR:          e.result = i_rs_data ^ i_rt_data;
                    FN_NOR:          e.result = ~(i_rs_data | i_rt_data);
                    FN_SLT:  e.result = NB_DATA'($signed(i_rs_data) < $signed(i_rt_data));
                    FN_JALR: e.result = i_pc + NB_DATA'(8);
                    default: e.illegal = 1'b1;
                endcase
            end
            OP_ADDI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: e.result = i_rs_data + sext;
            OP_SB, OP_SH, OP_SW: begin
                e.result    = i_rs_data + sext;     // Store address
                e.reg_write = 1'b0;
            end
            OP_ANDI: e.result = i_rs_data & zext;
            OP_ORI:  e.result = i_rs_data | zext;
            OP_XORI: e.result = i_rs_data ^ zext;
            OP_SLTI: e.result = NB_DATA'($signed(i_rs_data) < $signed(sext));
            OP_LUI:  e.result = sext << 16;
            OP_BEQ, OP_BNE: begin
                e.branch_cond = (i_rs_data == i_rt_data) ^ (i_opcode == OP_BNE);
                e.result      = NB_DATA'(e.branch_cond);
                e.reg_write   = 1'b0;
            end
            OP_JAL: begin
                e.result  = i_pc + NB_DATA'(8);
                e.wr_addr = LINK_REG;
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal)
            e.reg_write = 1'b0;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [NB_DATA-1:0] got,
                               input logic [NB_DATA-1:0] want);
        if (got !== want) begin
            err_count++;
            $display("error %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
        end
    endtask

    // Inputs and outputs are both read before this edge's updates land
    always @(posedge i_clk) begin
        if (!i_arst_n) begin
            model_q.delete();
        end else begin
            if (model_q.size() == 0) begin
                // First edge out of reset
                check_value("o_valid", NB_DATA'(i_ex_valid), '0);
                check_value("o_reg_write", NB_DATA'(i_ex_reg_write), '0);
                check_value("o_branch_cond", NB_DATA'(i_ex_branch_cond), '0);
                check_value("o_illegal", NB_DATA'(i_ex_illegal), '0);
            end else begin
                head = model_q.pop_front();
                if (i_ex_valid)
                    result_count++;
                check_value("o_valid", NB_DATA'(i_ex_valid), NB_DATA'(head.valid));
                check_value("o_reg_write", NB_DATA'(i_ex_reg_write), NB_DATA'(head.reg_write));
                if (head.valid) begin
                    check_value("o_branch_cond", NB_DATA'(i_ex_branch_cond),
                                NB_DATA'(head.branch_cond));
                    check_value("o_illegal", NB_DATA'(i_ex_illegal), NB_DATA'(head.illegal));
                    if (!head.illegal)
                        check_value("o_result", i_ex_result, head.result);
                    if (head.reg_write)
                        check_value("o_wr_addr", NB_DATA'(i_ex_wr_addr), NB_DATA'(head.wr_addr));
                end
            end
            model_q.push_back(predict_outputs());
        end
    end

    initial begin : reset_wait
        int cycles;
        reset_timeout = 1'b0;
        cycles        = 0;
        while (i_arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (i_arst_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            reset_timeout = 1'b1;
        end
    end

endmodule

/* ex_operand_mux.sv */
`timescale 1ns/100ps
module ex_operand_mux #(
    parameter int NB_DATA = 32
) (
    input  logic [NB_DATA-1:0]               i_rs_data,
    input  logic [NB_DATA-1:0]               i_rt_data,
    input  logic [mips_ex_pkg::NB_IMM-1:0]   i_imm,
    input  logic [mips_ex_pkg::NB_SHAMT-1:0] i_shamt,
    input  logic                             i_shamt_ctrl,  // 0 shamt field, 1 rs
    input  logic                             i_imm_ctrl,    // 1 selects immediate for B
    input  logic                             i_imm_zext,
    output logic [NB_DATA-1:0]               o_data_a,
    output logic [NB_DATA-1:0]               o_data_b,
    output logic [mips_ex_pkg::NB_SHAMT-1:0] o_shift_amt
);
    import mips_ex_pkg::*;

    logic              imm_fill;    // Upper fill bit of the immediate
    logic [NB_DATA-1:0] imm_ext;

    assign imm_fill = i_imm_zext ? 1'b0 : i_imm[NB_IMM-1];
    assign imm_ext  = {{(NB_DATA-NB_IMM){imm_fill}}, i_imm};

    assign o_data_a    = i_rs_data;
    assign o_data_b    = i_imm_ctrl ? imm_ext : i_rt_data;     // Shifts keep rt here
    assign o_shift_amt = i_shamt_ctrl ? i_rs_data[NB_SHAMT-1:0] : i_shamt;

endmodule

/* ex_result_reg.sv */
`timescale 1ns/100ps
module ex_result_reg #(
    parameter int NB_DATA = 32
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_valid,
    input  logic [NB_DATA-1:0]                  i_alu_result,
    input  logic [NB_DATA-1:0]                  i_pc,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rt_addr,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rd_addr,
    input  logic                                i_last_register_ctrl,
    input  logic                                i_reg_dst,
    input  logic                                i_reg_write,
    input  logic                                i_illegal,
    input  logic                                i_branch,
    output logic                                o_valid,
    output logic [NB_DATA-1:0]                  o_result,
    output logic [mips_ex_pkg::NB_REG_ADDR-1:0] o_wr_addr,
    output logic                                o_reg_write,
    output logic                                o_branch_cond,
    output logic                                o_illegal
);
    import mips_isa_pkg::*;

    logic [NB_DATA-1:0] result_nxt;
    logic [4:0]         wr_addr_nxt;

    assign result_nxt = i_last_register_ctrl ? (i_pc + NB_DATA'(8)) : i_alu_result;

    // jal has link set without reg_dst, jalr has both
    assign wr_addr_nxt = (i_last_register_ctrl && !i_reg_dst) ? LINK_REG :
                         i_reg_dst                            ? i_rd_addr : i_rt_addr;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_valid       <= 1'b0;
            o_reg_write   <= 1'b0;
            o_branch_cond <= 1'b0;
            o_illegal     <= 1'b0;
        end else begin
            o_valid       <= i_valid;
            o_reg_write   <= i_valid & i_reg_write;          // Bubble never writes
            o_branch_cond <= i_valid & i_branch & i_alu_result[0];
            o_illegal     <= i_valid & i_illegal;
        end
    end

    always_ff @(posedge i_clk) begin
        o_result  <= result_nxt;
        o_wr_addr <= wr_addr_nxt;
    end

    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !$isunknown(o_valid));

    // Decode must never let an illegal instruction write the register file
    a_illegal_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_illegal |-> !o_reg_write);

endmodule

/* ex_stage.sv */
`timescale 1ns/100ps
module ex_stage #(
    parameter int NB_DATA = 32
) (
    input  logic                                i_clk,
    input  logic                                i_arst_n,
    input  logic                                i_valid,
    input  logic [mips_ex_pkg::NB_OPCODE-1:0]   i_opcode,
    input  logic [mips_ex_pkg::NB_FCODE-1:0]    i_funct,
    input  logic [mips_ex_pkg::NB_SHAMT-1:0]    i_shamt,
    input  logic [mips_ex_pkg::NB_IMM-1:0]      i_imm,
    input  logic [NB_DATA-1:0]                  i_rs_data,
    input  logic [NB_DATA-1:0]                  i_rt_data,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rt_addr,
    input  logic [mips_ex_pkg::NB_REG_ADDR-1:0] i_rd_addr,
    input  logic [NB_DATA-1:0]                  i_pc,
    output logic                                o_valid,
    output logic [NB_DATA-1:0]                  o_result,
    output logic [mips_ex_pkg::NB_REG_ADDR-1:0] o_wr_addr,
    output logic                                o_reg_write,
    output logic                                o_branch_cond,
    output logic                                o_illegal
);
    import mips_isa_pkg::*;
    import mips_ex_pkg::*;

    alu_op_e              alu_op;
    logic                 shamt_ctrl;
    logic                 imm_ctrl;
    logic                 imm_zext;
    logic                 last_register_ctrl;
    logic                 reg_dst;
    logic                 reg_write;
    logic                 branch;
    logic                 illegal;
    logic [NB_DATA-1:0]   data_a;
    logic [NB_DATA-1:0]   data_b;
    logic [NB_SHAMT-1:0]  shift_amt;
    logic [NB_DATA-1:0]   alu_result;

    alu_control u_alu_control (
        .i_funct_code         (funct_e'(i_funct)),   // Raw codes may be illegal
        .i_alu_op             (opcode_e'(i_opcode)),
        .o_alu_ctrl           (alu_op),
        .o_shamt_ctrl         (shamt_ctrl),
        .o_imm_ctrl           (imm_ctrl),
        .o_imm_zext           (imm_zext),
        .o_last_register_ctrl (last_register_ctrl),
        .o_reg_dst            (reg_dst),
        .o_reg_write          (reg_write),
        .o_branch             (branch),
        .o_illegal            (illegal)
    );

    ex_operand_mux #(.NB_DATA(NB_DATA)) u_ex_operand_mux (
        .i_rs_data    (i_rs_data),
        .i_rt_data    (i_rt_data),
        .i_imm        (i_imm),
        .i_shamt      (i_shamt),
        .i_shamt_ctrl (shamt_ctrl),
        .i_imm_ctrl   (imm_ctrl),
        .i_imm_zext   (imm_zext),
        .o_data_a     (data_a),
        .o_data_b     (data_b),
        .o_shift_amt  (shift_amt)
    );

    alu #(.NB_DATA(NB_DATA)) u_alu (
        .i_alu_op    (alu_op),
        .i_data_a    (data_a),
        .i_data_b    (data_b),
        .i_shift_amt (shift_amt),
        .o_result    (alu_result)
    );

    ex_result_reg #(.NB_DATA(NB_DATA)) u_ex_result_reg (
        .i_clk                (i_clk),
        .i_arst_n             (i_arst_n),
        .i_valid              (i_valid),
        .i_alu_result         (alu_result),
        .i_pc                 (i_pc),
        .i_rt_addr            (i_rt_addr),
        .i_rd_addr            (i_rd_addr),
        .i_last_register_ctrl (last_register_ctrl),
        .i_reg_dst            (reg_dst),
        .i_reg_write          (reg_write),
        .i_illegal            (illegal),
        .i_branch             (branch),
        .o_valid              (o_valid),
        .o_result             (o_result),
        .o_wr_addr            (o_wr_addr),
        .o_reg_write          (o_reg_write),
        .o_branch_cond        (o_branch_cond),
        .o_illegal            (o_illegal)
    );

endmodule

/* mips_ex.f */
mips_isa_pkg.sv
mips_ex_pkg.sv
alu_control.sv
ex_operand_mux.sv
alu.sv
ex_result_reg.sv
ex_stage.sv
ex_checker.sv
tb_ex_stage.sv

/* mips_ex_pkg.sv */
package mips_ex_pkg;

    // Instruction field widths
    localparam int NB_FCODE    = 6;
    localparam int NB_OPCODE   = 6;
    localparam int NB_SHAMT    = 5;
    localparam int NB_IMM      = 16;
    localparam int NB_REG_ADDR = 5;

    // ALU operations, numbered as in the ALU control decode
    typedef enum logic [3:0] {
        ALU_SLL = 4'h0,
        ALU_SRL = 4'h1,
        ALU_SRA = 4'h2,
        ALU_ADD = 4'h3,
        ALU_SUB = 4'h4,
        ALU_AND = 4'h5,
        ALU_OR  = 4'h6,
        ALU_XOR = 4'h7,
        ALU_NOR = 4'h8,
        ALU_SLT = 4'h9,
        ALU_LUI = 4'ha,
        ALU_BEQ = 4'hb,
        ALU_BNE = 4'hc
    } alu_op_e;

endpackage

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // Primary opcodes, standard MIPS encodings
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_LWU   = 6'h27,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    localparam logic [4:0] LINK_REG = 5'd31;    // Return address register ($ra)

endpackage

/* tb_ex_stage.sv */
`timescale 1ns/100ps
module tb_ex_stage;
    import mips_isa_pkg::*;

    localparam int NB_DATA       = 32;
    localparam int NUM_INSTR     = 3000;
    localparam int DRAIN_TIMEOUT = 20;

    // R-type listed several times so it gets drawn more often
    localparam logic [5:0] OPCODES [24] = '{
        OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE,
        OP_LB, OP_LH, OP_LW, OP_LWU, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_BEQ, OP_BNE, OP_JAL
    };
    localparam logic [5:0] FUNCTS [16] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU,
        FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_JALR
    };

    logic               i_clk;
    logic               i_arst_n;
    logic               i_valid;
    logic [5:0]         i_opcode;
    logic [5:0]         i_funct;
    logic [4:0]         i_shamt;
    logic [15:0]        i_imm;
    logic [NB_DATA-1:0] i_rs_data;
    logic [NB_DATA-1:0] i_rt_data;
    logic [4:0]         i_rt_addr;
    logic [4:0]         i_rd_addr;
    logic [NB_DATA-1:0] i_pc;
    logic               o_valid;
    logic [NB_DATA-1:0] o_result;
    logic [4:0]         o_wr_addr;
    logic               o_reg_write;
    logic               o_branch_cond;
    logic               o_illegal;
    int                 seed;
    int                 n_sent;           // Valid instructions driven
    int                 check_errors;
    int                 timeout_errors;
    int                 result_count;
    int                 wait_cycles;

    always #4 i_clk = ~i_clk;               // 8 ns period

    ex_stage #(.NB_DATA(NB_DATA)) u_ex_stage (.*);

    ex_checker #(.NB_DATA(NB_DATA)) u_ex_checker (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_valid          (i_valid),
        .i_opcode         (i_opcode),
        .i_funct          (i_funct),
        .i_shamt          (i_shamt),
        .i_imm            (i_imm),
        .i_rs_data        (i_rs_data),
        .i_rt_data        (i_rt_data),
        .i_rt_addr        (i_rt_addr),
        .i_rd_addr        (i_rd_addr),
        .i_pc             (i_pc),
        .i_ex_valid       (o_valid),
        .i_ex_result      (o_result),
        .i_ex_wr_addr     (o_wr_addr),
        .i_ex_reg_write   (o_reg_write),
        .i_ex_branch_cond (o_branch_cond),
        .i_ex_illegal     (o_illegal),
        .o_error_count    (check_errors),
        .o_result_count   (result_count)
    );

    function automatic int random_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic drive_instruction();
        logic               v;
        logic [31:0]        fields;
        logic [31:0]        misc;
        logic [NB_DATA-1:0] rs;
        v      = (random_below(10) != 0);     // About 90% valid
        fields = $random(seed);
        misc   = $random(seed);
        rs     = $random(seed);
        i_valid   <= v;
        i_opcode  <= (random_below(100) < 8) ? fields[5:0] : OPCODES[random_below(24)];
        i_funct   <= (random_below(100) < 8) ? fields[11:6] : FUNCTS[random_below(16)];
        i_shamt   <= fields[16:12];
        i_imm     <= misc[15:0];
        i_rt_addr <= misc[20:16];
        i_rd_addr <= misc[25:21];
        i_rs_data <= rs;
        i_rt_data <= (random_below(4) == 0) ? rs : $random(seed);   // Equal operands for beq
        i_pc      <= $random(seed) & ~32'h3;
        if (v)
            n_sent++;
    endtask

    initial begin
        seed           = 32'h579d;
        n_sent         = 0;
        timeout_errors = 0;
        wait_cycles    = 0;
        i_clk          = 1'b0;
        i_arst_n       = 1'b0;
        i_valid        = 1'b0;
        i_opcode       = '0;
        i_funct        = '0;
        i_shamt        = '0;
        i_imm          = '0;
        i_rs_data      = '0;
        i_rt_data      = '0;
        i_rt_addr      = '0;
        i_rd_addr      = '0;
        i_pc           = '0;
        repeat (2) @(posedge i_clk);
        i_arst_n <= 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            @(posedge i_clk);
            drive_instruction();
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        while (result_count < n_sent && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge i_clk);
            wait_cycles++;
        end
        if (result_count < n_sent) begin
            $display("Timeout waiting for results, %0d of %0d seen", result_count, n_sent);
            timeout_errors++;
        end
        @(negedge i_clk);
        $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
